// ==== sim/issue_stim.txt ====
# name cwe cad cdata c1 c2 cd sb1 v1 sb2 v2 fu rs1 rs2 rd imm pc flg ctl ack stb exp_a exp_b
# flg=ex,zimm,pc,imm ctl=valid,stall,flu,lsu,flush; fu/stb 0none 1alu 2br 3mul 4ld 5st 6csr
wr_x20 1 20 cafe0001 0 0 0 0 0 0 0 1 20 3 5 0 80000000 0000 10110 1 1 rf rf
rd_x20 0 0 0 0 0 0 0 0 0 0 1 20 20 5 0 80000004 0000 10110 1 1 cafe0001 cafe0001
wr_x0 1 0 ffffffff 0 0 0 0 0 0 0 1 0 0 5 0 80000008 0000 10110 1 1 0 0
rd_x0 0 0 0 0 0 0 0 0 0 0 1 0 0 5 0 8000000c 0000 10110 1 1 0 0
fwd_alu 0 0 0 1 0 0 12345678 1 0 0 1 4 5 6 0 80000010 0000 10110 1 1 12345678 rf
fwd_mult 0 0 0 0 3 0 0 0 0badf00d 1 1 4 7 6 0 80000014 0000 10110 1 1 rf 0badf00d
no_fwd_csr 0 0 0 6 0 0 12345678 1 0 0 1 4 5 6 0 80000018 0000 10110 0 0 x x
no_fwd_inval 0 0 0 0 1 0 0 0 0 0 1 4 7 6 0 8000001c 0000 10110 0 0 x x
waw_block 0 0 0 0 0 4 0 0 0 0 1 1 2 9 0 80000020 0000 10110 0 0 x x
waw_commit 1 9 99 0 0 4 0 0 0 0 1 1 2 9 0 80000024 0000 10110 1 1 rf rf
auipc_pc 0 0 0 0 0 0 0 0 0 0 1 0 0 10 1000 80000028 0011 10110 1 1 80000028 1000
csr_zimm 0 0 0 1 0 0 0 0 0 0 6 13 0 8 300 8000002c 0101 10110 1 6 d 300
store_imm 0 0 0 0 0 0 0 0 0 0 5 2 3 0 10 80000030 0001 10110 1 5 rf rf
branch_imm 0 0 0 0 0 0 0 0 0 0 2 1 2 0 20 80000034 0001 10110 1 2 rf rf
load_imm 0 0 0 0 0 0 0 0 0 0 4 2 0 11 8 80000038 0001 10110 1 4 rf 8
flush_kill 0 0 0 0 0 0 0 0 0 0 1 1 2 12 0 8000003c 0000 10111 1 0 rf rf
ex_stall 0 0 0 0 0 0 0 0 0 0 1 1 2 12 0 80000040 1000 11000 1 0 x x
none_stall 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 80000044 0000 11000 1 0 x x
flu_busy 0 0 0 0 0 0 0 0 0 0 1 1 2 12 0 80000048 0000 10010 0 0 x x
lsu_busy 0 0 0 0 0 0 0 0 0 0 4 2 0 11 8 8000004c 0001 10100 0 0 x x
mult_first 0 0 0 0 0 0 0 0 0 0 3 3 4 13 0 80000050 0000 10110 1 3 rf rf
mult_second 0 0 0 0 0 0 0 0 0 0 3 5 6 14 0 80000054 0000 10110 1 3 rf rf
alu_blocked 0 0 0 0 0 0 0 0 0 0 1 1 2 15 0 80000058 0000 10110 0 0 x x
alu_after 0 0 0 0 0 0 0 0 0 0 1 1 2 15 0 8000005c 0000 10110 1 1 rf rf

// ==== all.f ====
common/issue_pkg.sv
source/int_regfile.sv
issue/issue_hazard.sv
issue/operand_mux.sv
issue/dispatch_regs.sv
issue/issue_top.sv
sim/tb_issue.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the issue stage testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_issue -Mdir obj_dir -o tb_issue
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_issue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0

// ==== sim/tb_issue.sv ====
// testbench for the issue stage; reads sim/issue_stim.txt, drives one step per cycle and checks the DUT

`timescale 1ns/100ps

module tb_issue;

  import issue_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int NR_COMMIT_PORTS = 2;
  // time allowed per test step, plus room for reset and register fill
  localparam int STEP_NS   = 300;
  localparam int MARGIN_NS = 2000;
  // registers x1..x15 get random contents before the steps run
  localparam int FILL_REGS = 15;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               flush;
  logic                               stall;
  issue_entry_t                       issue_instr;
  logic                               issue_instr_valid;
  logic                               issue_ack;
  logic                               stall_issue;
  reg_addr_t                          rs1_addr;
  reg_addr_t                          rs2_addr;
  xlen_t                              rs1_val;
  xlen_t                              rs2_val;
  logic                               rs1_valid;
  logic                               rs2_valid;
  clobber_t                           rd_clobber;
  commit_port_t [NR_COMMIT_PORTS-1:0] commit;
  logic                               flu_ready;
  logic                               lsu_ready;
  fu_data_t                           fu_data;
  pc_t                                pc;
  logic                               alu_valid;
  logic                               branch_valid;
  logic                               lsu_valid;
  logic                               mult_valid;
  logic                               csr_valid;

  int    seed   = 24;
  int    errors = 0;
  int    checks = 0;
  logic  loaded = 1'b0;
  string steps[$];
  // expected register contents, x0 stays zero
  xlen_t shadow [NR_REGS];

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  issue_top #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) issue_top_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush),
    .stall_i            (stall),
    .issue_instr_i      (issue_instr),
    .issue_instr_valid_i(issue_instr_valid),
    .issue_ack_o        (issue_ack),
    .stall_issue_o      (stall_issue),
    .rs1_o              (rs1_addr),
    .rs1_i              (rs1_val),
    .rs1_valid_i        (rs1_valid),
    .rs2_o              (rs2_addr),
    .rs2_i              (rs2_val),
    .rs2_valid_i        (rs2_valid),
    .rd_clobber_i       (rd_clobber),
    .commit_i           (commit),
    .flu_ready_i        (flu_ready),
    .lsu_ready_i        (lsu_ready),
    .fu_data_o          (fu_data),
    .pc_o               (pc),
    .alu_valid_o        (alu_valid),
    .branch_valid_o     (branch_valid),
    .lsu_valid_o        (lsu_valid),
    .mult_valid_o       (mult_valid),
    .csr_valid_o        (csr_valid)
  );

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_logic(input string test, input string sig, input logic exp,
                             input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %b, actual %b", test, sig, exp, act);
    end
  endtask

  task automatic check_xlen(input string test, input string sig, input xlen_t exp,
                            input xlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test, sig, exp, act);
    end
  endtask

  task automatic check_fu(input string test, input string sig, input fu_t exp, input fu_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %s, actual %s (%0d)", test, sig, exp.name(),
               act.name(), act);
    end
  endtask

  task automatic check_addr(input string test, input string sig, input reg_addr_t exp,
                            input reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %0d, actual %0d", test, sig, exp, act);
    end
  endtask

  task automatic check_pc(input string test, input string sig, input pc_t exp, input pc_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test, sig, exp, act);
    end
  endtask

  task automatic check_op(input string test, input string sig, input op_t exp, input op_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test, sig, exp, act);
    end
  endtask

  task automatic check_tid(input string test, input string sig, input trans_id_t exp,
                           input trans_id_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %0d, actual %0d", test, sig, exp, act);
    end
  endtask

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // called just after the edge, while commit still holds this cycle's writes
  task automatic track_commits();
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (commit[p].we && (commit[p].waddr != '0)) begin
        shadow[commit[p].waddr] = commit[p].wdata;
      end
    end
  endtask

  // both commit ports in parallel, two registers per cycle
  task automatic fill_registers();
    xlen_t val;
    for (int r = 1; r <= FILL_REGS; r += 2) begin
      @(negedge clk_i);
      commit = '0;
      for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
        if (r + p <= FILL_REGS) begin
          val              = $random(seed);
          commit[p].we     = 1'b1;
          commit[p].waddr  = reg_addr_t'(r + p);
          commit[p].wdata  = val;
        end
      end
      @(posedge clk_i);
      #1;
      track_commits();
    end
    @(negedge clk_i);
    commit = '0;
  endtask

  // one stimulus line: drive on the falling edge, ack before the rising edge,
  // strobes and bundle just after it
  task automatic run_step(input string line, input int idx);
    logic [8*24-1:0] name_raw;
    logic [8*12-1:0] tok_a_raw;
    logic [8*12-1:0] tok_b_raw;
    string           test;
    string           tok_a;
    string           tok_b;
    logic            cwe;
    reg_addr_t       cad;
    xlen_t           cdata;
    logic [2:0]      c1;
    logic [2:0]      c2;
    logic [2:0]      cd;
    xlen_t           sb1;
    xlen_t           sb2;
    logic            v1;
    logic            v2;
    logic [2:0]      fu;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    reg_addr_t       rd;
    xlen_t           imm;
    pc_t             pc_in;
    logic [3:0]      flg;
    logic [4:0]      ctl;
    logic            exp_ack;
    logic [2:0]      stb;
    fu_t             unit;
    fu_t             own1;
    fu_t             own2;
    logic            exp_stall;
    xlen_t           exp_a;
    xlen_t           exp_b;
    issue_entry_t    e;
    int              n;
    n = $sscanf(line, "%s %d %d %h %d %d %d %h %d %h %d %d %d %d %d %h %h %b %b %d %d %s %s",
                name_raw, cwe, cad, cdata, c1, c2, cd, sb1, v1, sb2, v2,
                fu, rs1, rs2, rd, imm, pc_in, flg, ctl, exp_ack, stb, tok_a_raw, tok_b_raw);
    if (n != 23) begin
      errors++;
      $display("stimulus line %0d could not be parsed: %s", idx, line);
    end else begin
      test  = string'(name_raw);
      tok_a = string'(tok_a_raw);
      tok_b = string'(tok_b_raw);
      unit  = fu_t'(stb);
      @(negedge clk_i);
      commit          = '0;
      commit[1].we    = cwe;
      commit[1].waddr = cad;
      commit[1].wdata = cdata;
      for (int r = 0; r < NR_REGS; r++) begin
        rd_clobber[r] = NONE;
      end
      if (c2 != 3'd0) rd_clobber[rs2] = fu_t'(c2);
      if (c1 != 3'd0) rd_clobber[rs1] = fu_t'(c1);
      if (cd != 3'd0) rd_clobber[rd] = fu_t'(cd);
      e          = '0;
      e.pc       = pc_in;
      e.fu       = fu_t'(fu);
      e.op       = op_t'(idx);
      e.rs1      = rs1;
      e.rs2      = rs2;
      e.rd       = rd;
      e.result   = imm;
      e.use_imm  = flg[0];
      e.use_pc   = flg[1];
      e.use_zimm = flg[2];
      e.ex_valid = flg[3];
      e.trans_id = trans_id_t'(idx);
      issue_instr       = e;
      issue_instr_valid = ctl[4];
      stall             = ctl[3];
      flu_ready         = ctl[2];
      lsu_ready         = ctl[1];
      flush             = ctl[0];
      rs1_val           = sb1;
      rs1_valid         = v1;
      rs2_val           = sb2;
      rs2_valid         = v2;
      // a clobbered source stalls unless a non-CSR value can be forwarded
      own1      = rd_clobber[rs1];
      own2      = rd_clobber[rs2];
      exp_stall = ctl[3];
      if (!flg[2] && (own1 != NONE) && (!v1 || (own1 == CSR))) exp_stall = 1'b1;
      if ((own2 != NONE) && (!v2 || (own2 == CSR))) exp_stall = 1'b1;
      // rf names the register contents seen before this edge
      exp_a = '0;
      exp_b = '0;
      if (tok_a == "rf") exp_a = shadow[rs1];
      else if (tok_a != "x") void'($sscanf(tok_a, "%h", exp_a));
      if (tok_b == "rf") exp_b = shadow[rs2];
      else if (tok_b != "x") void'($sscanf(tok_b, "%h", exp_b));
      #(CLK_PERIOD/4);
      check_logic(test, "issue_ack_o", exp_ack, issue_ack);
      check_logic(test, "stall_issue_o", exp_stall, stall_issue);
      check_addr(test, "rs1_o", rs1, rs1_addr);
      check_addr(test, "rs2_o", rs2, rs2_addr);
      @(posedge clk_i);
      #1;
      check_logic(test, "alu_valid_o", unit == ALU, alu_valid);
      check_logic(test, "branch_valid_o", unit == CTRL_FLOW, branch_valid);
      check_logic(test, "lsu_valid_o", (unit == LOAD) || (unit == STORE), lsu_valid);
      check_logic(test, "mult_valid_o", unit == MULT, mult_valid);
      check_logic(test, "csr_valid_o", unit == CSR, csr_valid);
      check_fu(test, "fu_data_o.fu", fu_t'(fu), fu_data.fu);
      check_op(test, "fu_data_o.op", op_t'(idx), fu_data.op);
      check_tid(test, "fu_data_o.trans_id", trans_id_t'(idx), fu_data.trans_id);
      check_xlen(test, "fu_data_o.imm", imm, fu_data.imm);
      check_pc(test, "pc_o", pc_in, pc);
      if (tok_a != "x") check_xlen(test, "operand_a", exp_a, fu_data.operand_a);
      if (tok_b != "x") check_xlen(test, "operand_b", exp_b, fu_data.operand_b);
      track_commits();
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    int    fd;
    string line;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    flush             = 1'b0;
    stall             = 1'b0;
    issue_instr       = '0;
    issue_instr_valid = 1'b0;
    rs1_val           = '0;
    rs2_val           = '0;
    rs1_valid         = 1'b0;
    rs2_valid         = 1'b0;
    commit            = '0;
    flu_ready         = 1'b1;
    lsu_ready         = 1'b1;
    for (int r = 0; r < NR_REGS; r++) begin
      rd_clobber[r] = NONE;
      shadow[r]     = '0;
    end
    fd = $fopen("sim/issue_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("the stimulus file sim/issue_stim.txt could not be opened");
    end else begin
      // comment and blank lines are skipped
      while (!$feof(fd)) begin
        line = "";
        if (($fgets(line, fd) > 0) && (line.len() > 1) && (line[0] != "#")) begin
          steps.push_back(line);
        end
      end
      $fclose(fd);
      loaded = 1'b1;
      if (steps.size() == 0) begin
        errors++;
        $display("the stimulus file holds no test steps");
      end else begin
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        fill_registers();
        foreach (steps[i]) begin
          run_step(steps[i], i);
        end
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog, sized from the number of test steps
  initial begin : watchdog
    wait (loaded);
    #(steps.size() * STEP_NS + MARGIN_NS);
    $display("timeout: the test steps did not finish in the allowed time");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== issue/issue_top.sv ====
// operand-read and issue stage top; hooks hazard check, register file, operand mux and execute registers

`timescale 1ns/100ps

module issue_top #(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_i,
  input  logic                                          stall_i,
  input  issue_pkg::issue_entry_t                       issue_instr_i,
  input  logic                                          issue_instr_valid_i,
  output logic                                          issue_ack_o,
  output logic                                          stall_issue_o,
  output issue_pkg::reg_addr_t                          rs1_o,
  input  issue_pkg::xlen_t                              rs1_i,
  input  logic                                          rs1_valid_i,
  output issue_pkg::reg_addr_t                          rs2_o,
  input  issue_pkg::xlen_t                              rs2_i,
  input  logic                                          rs2_valid_i,
  input  issue_pkg::clobber_t                           rd_clobber_i,
  input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
  input  logic                                          flu_ready_i,
  input  logic                                          lsu_ready_i,
  output issue_pkg::fu_data_t                           fu_data_o,
  output issue_pkg::pc_t                                pc_o,
  output logic                                          alu_valid_o,
  output logic                                          branch_valid_o,
  output logic                                          lsu_valid_o,
  output logic                                          mult_valid_o,
  output logic                                          csr_valid_o
);

  import issue_pkg::*;

  logic     fwd_rs1;
  logic     fwd_rs2;
  logic     dispatch;
  logic     mult_pending;
  xlen_t    rdata_a;
  xlen_t    rdata_b;
  fu_data_t next_data;

  // scoreboard lookup by source index
  assign rs1_o = issue_instr_i.rs1;
  assign rs2_o = issue_instr_i.rs2;

  issue_hazard #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) issue_hazard_inst (
    .issue_instr_i      (issue_instr_i),
    .issue_instr_valid_i(issue_instr_valid_i),
    .stall_i            (stall_i),
    .rd_clobber_i       (rd_clobber_i),
    .rs1_valid_i        (rs1_valid_i),
    .rs2_valid_i        (rs2_valid_i),
    .commit_i           (commit_i),
    .flu_ready_i        (flu_ready_i),
    .lsu_ready_i        (lsu_ready_i),
    .mult_pending_i     (mult_pending),
    .fwd_rs1_o          (fwd_rs1),
    .fwd_rs2_o          (fwd_rs2),
    .issue_ack_o        (issue_ack_o),
    .stall_o            (stall_issue_o),
    .dispatch_o         (dispatch)
  );

  int_regfile #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) int_regfile_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(issue_instr_i.rs1),
    .raddr_b_i(issue_instr_i.rs2),
    .commit_i (commit_i),
    .rdata_a_o(rdata_a),
    .rdata_b_o(rdata_b)
  );

  operand_mux operand_mux_inst (
    .issue_instr_i(issue_instr_i),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .fwd_rs1_i    (fwd_rs1),
    .fwd_rs2_i    (fwd_rs2),
    .next_data_o  (next_data)
  );

  // execute side sees the entry one edge after acceptance
  dispatch_regs dispatch_regs_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .dispatch_i    (dispatch),
    .next_data_i   (next_data),
    .pc_i          (issue_instr_i.pc),
    .fu_data_o     (fu_data_o),
    .pc_o          (pc_o),
    .alu_valid_o   (alu_valid_o),
    .branch_valid_o(branch_valid_o),
    .lsu_valid_o   (lsu_valid_o),
    .mult_valid_o  (mult_valid_o),
    .csr_valid_o   (csr_valid_o),
    .mult_pending_o(mult_pending)
  );

endmodule

// ==== issue/dispatch_regs.sv ====
// issue-to-execute pipeline registers and the one-cycle-late unit valid strobes

`timescale 1ns/100ps

module dispatch_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                dispatch_i,
  input  issue_pkg::fu_data_t next_data_i,
  input  issue_pkg::pc_t      pc_i,
  output issue_pkg::fu_data_t fu_data_o,
  output issue_pkg::pc_t      pc_o,
  output logic                alu_valid_o,
  output logic                branch_valid_o,
  output logic                lsu_valid_o,
  output logic                mult_valid_o,
  output logic                csr_valid_o,
  output logic                mult_pending_o
);

  import issue_pkg::*;

  // ----------------------------------------
  // unit strobes
  // ----------------------------------------
  // every strobe lasts a single cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : strobe_regs
    if (!rst_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
      if (dispatch_i) begin
        unique case (next_data_i.fu)
          ALU:         alu_valid_o    <= 1'b1;
          CTRL_FLOW:   branch_valid_o <= 1'b1;
          MULT:        mult_valid_o   <= 1'b1;
          LOAD, STORE: lsu_valid_o    <= 1'b1;
          CSR:         csr_valid_o    <= 1'b1;
          default:     ;
        endcase
      end
      // a flush must not start a unit on stale operands
      if (flush_i) begin
        alu_valid_o    <= 1'b0;
        branch_valid_o <= 1'b0;
        lsu_valid_o    <= 1'b0;
        mult_valid_o   <= 1'b0;
        csr_valid_o    <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // operand bundle
  // ----------------------------------------
  // captured every cycle, the strobes say when it counts
  always_ff @(posedge clk_i or negedge rst_ni) begin : bundle_regs
    if (!rst_ni) begin
      fu_data_o <= '{fu: NONE, default: '0};
      pc_o      <= '0;
    end else begin
      fu_data_o <= next_data_i;
      pc_o      <= pc_i;
    end
  end

  // multiply in flight, blocks fixed-latency issue for one cycle
  assign mult_pending_o = mult_valid_o;

  // a dispatched entry must carry a known unit code
  a_fu_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dispatch_i |-> !$isunknown(next_data_i.fu));

endmodule

// ==== issue/operand_mux.sv ====
// combinational build of operand A, operand B and the immediate for the execute bundle

`timescale 1ns/100ps

module operand_mux (
  input  issue_pkg::issue_entry_t issue_instr_i,
  input  issue_pkg::xlen_t        rdata_a_i,
  input  issue_pkg::xlen_t        rdata_b_i,
  input  issue_pkg::xlen_t        rs1_i,
  input  issue_pkg::xlen_t        rs2_i,
  input  logic                    fwd_rs1_i,
  input  logic                    fwd_rs2_i,
  output issue_pkg::fu_data_t     next_data_o
);

  import issue_pkg::*;

  xlen_t operand_a;
  xlen_t operand_b;

  // later assignments take priority over earlier ones
  always_comb begin : operand_select
    operand_a = rdata_a_i;
    operand_b = rdata_b_i;
    if (fwd_rs1_i) begin
      operand_a = rs1_i;
    end
    if (fwd_rs2_i) begin
      operand_b = rs2_i;
    end
    // auipc, jal and friends
    if (issue_instr_i.use_pc) begin
      operand_a = xlen_t'(issue_instr_i.pc);
    end
    // csr immediate forms, zero extended
    if (issue_instr_i.use_zimm) begin
      operand_a = {{(XLEN-REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
    end
    // stores and branches keep rs2 in B, they read the immediate from imm
    if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE) &&
        (issue_instr_i.fu != CTRL_FLOW)) begin
      operand_b = issue_instr_i.result;
    end
  end

  assign next_data_o.fu        = issue_instr_i.fu;
  assign next_data_o.op        = issue_instr_i.op;
  assign next_data_o.operand_a = operand_a;
  assign next_data_o.operand_b = operand_b;
  assign next_data_o.imm       = issue_instr_i.result;
  assign next_data_o.trans_id  = issue_instr_i.trans_id;

endmodule

// ==== issue/issue_hazard.sv ====
// combinational issue check: operand availability, forwarding select, unit busy, WAW and acknowledge

`timescale 1ns/100ps

module issue_hazard #(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  issue_pkg::issue_entry_t                       issue_instr_i,
  input  logic                                          issue_instr_valid_i,
  input  logic                                          stall_i,
  input  issue_pkg::clobber_t                           rd_clobber_i,
  input  logic                                          rs1_valid_i,
  input  logic                                          rs2_valid_i,
  input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
  input  logic                                          flu_ready_i,
  input  logic                                          lsu_ready_i,
  input  logic                                          mult_pending_i,
  output logic                                          fwd_rs1_o,
  output logic                                          fwd_rs2_o,
  output logic                                          issue_ack_o,
  output logic                                          stall_o,
  output logic                                          dispatch_o
);

  import issue_pkg::*;

  logic fu_busy;
  logic rd_free;
  fu_t  rs1_owner;
  fu_t  rs2_owner;

  assign rs1_owner = rd_clobber_i[issue_instr_i.rs1];
  assign rs2_owner = rd_clobber_i[issue_instr_i.rs2];

  // ready level of the unit the entry wants
  always_comb begin : unit_busy
    unique case (issue_instr_i.fu)
      ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ----------------------------------------
  // source operands
  // ----------------------------------------
  // a pending writer means forward from the scoreboard or wait
  // CSR results only ever come back through the register file
  always_comb begin : operands_available
    stall_o   = stall_i;
    fwd_rs1_o = 1'b0;
    fwd_rs2_o = 1'b0;
    // zimm lives in the rs1 field, nothing to wait for then
    if (!issue_instr_i.use_zimm && (rs1_owner != NONE)) begin
      if (rs1_valid_i && (rs1_owner != CSR)) begin
        fwd_rs1_o = 1'b1;
      end else begin
        stall_o = 1'b1;
      end
    end
    if (rs2_owner != NONE) begin
      if (rs2_valid_i && (rs2_owner != CSR)) begin
        fwd_rs2_o = 1'b1;
      end else begin
        stall_o = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // WAW and acknowledge
  // ----------------------------------------
  // rd is free if nobody owns it or its owner retires right now
  always_comb begin : waw_check
    rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);
    for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
        rd_free = 1'b1;
      end
    end
  end

  always_comb begin : issue_ack
    issue_ack_o = 1'b0;
    if (issue_instr_valid_i) begin
      if (!stall_o && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less entries just drain
      if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // multiplier result owns the fixed-latency writeback next cycle
    if (mult_pending_i && (issue_instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

  assign dispatch_o = issue_instr_valid_i & issue_ack_o & ~issue_instr_i.ex_valid;

endmodule

// ==== source/int_regfile.sv ====
// integer register file with two combinational read ports and a configurable number of commit ports

`timescale 1ns/100ps

module int_regfile #(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  issue_pkg::reg_addr_t                          raddr_a_i,
  input  issue_pkg::reg_addr_t                          raddr_b_i,
  input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
  output issue_pkg::xlen_t                              rdata_a_o,
  output issue_pkg::xlen_t                              rdata_b_o
);

  import issue_pkg::*;

  // x0 is cleared by reset and never written
  xlen_t regs_q [NR_REGS];

  // ----------------------------------------
  // write ports
  // ----------------------------------------
  // ports are walked in index order, so on an address clash the
  // last (highest) port's data is what lands in the register
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NR_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
        if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
          regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
        end
      end
    end
  end

  // ----------------------------------------
  // read ports
  // ----------------------------------------
  // no bypass, a write shows up from the cycle after the edge
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // an enabled write must name a real register
  for (genvar p = 0; p < NR_COMMIT_PORTS; p++) begin : gen_waddr_chk
    a_waddr_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_i[p].we |-> !$isunknown(commit_i[p].waddr));
  end

endmodule

// ==== common/issue_pkg.sv ====
// shared widths, the functional-unit code and the packed issue-stage bundles; import in every issue RTL file

package issue_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned VLEN       = 32;
  localparam int unsigned REG_ADDR_W = $clog2(NR_REGS);
  localparam int unsigned TRANS_ID_W = 3;
  localparam int unsigned OP_W       = 7;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [VLEN-1:0]       pc_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [OP_W-1:0]       op_t;

  // functional unit an instruction is steered to
  // NONE marks instructions that finish without any unit
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    ALU       = 3'd1,
    CTRL_FLOW = 3'd2,
    MULT      = 3'd3,
    LOAD      = 3'd4,
    STORE     = 3'd5,
    CSR       = 3'd6
  } fu_t;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  // decoded entry as handed over by the scoreboard
  // result holds the immediate, rs1 doubles as zimm
  typedef struct packed {
    pc_t       pc;
    fu_t       fu;
    op_t       op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     result;
    logic      use_imm;
    logic      use_pc;
    logic      use_zimm;
    trans_id_t trans_id;
    logic      ex_valid;
  } issue_entry_t;

  // operand bundle going to the execute units
  typedef struct packed {
    fu_t       fu;
    op_t       op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

  // one register write from the commit stage
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;
  } commit_port_t;

  // per register, the unit that is going to write it
  typedef fu_t [NR_REGS-1:0] clobber_t;

endpackage
